/* Makefile */
# Verilator build and run for the execution lane

.PHONY: sim clean

sim:
	verilator --binary --timing -f compile.f --top-module exLaneTb -o exLaneSim
	./obj_dir/exLaneSim | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
laneDefs.sv
exLaneAlu.sv
exLaneMulw.sv
exLaneStage1.sv
exLaneStage2.sv
exLaneTop.sv
exLaneTb.sv

/* exLaneAlu.sv */
// Lane ALU and compare unit
`timescale 1ns/1ps
`default_nettype none

module exLaneAlu (
	input wire laneDefs::laneAluFunc func,
	input wire laneDefs::laneCmpCond cond,
	input wire [laneDefs::laneDataWidth-1:0] a,
	input wire [laneDefs::laneDataWidth-1:0] b,
	output logic [laneDefs::laneDataWidth-1:0] result,
	output logic cmpT
);
	import laneDefs::*;

	logic [laneDataWidth-1:0] sum;		// a + b
	logic [laneDataWidth-1:0] diff;		// a - b
	logic isEq;
	logic isGt;

	// Adder and subtractor wrap, carry dropped
	assign sum = a + b;
	assign diff = a - b;

	assign isEq = (a == b);
	assign isGt = ($signed(a) > $signed(b));		// Signed compare

	always_comb begin
		case (func)
			aluAdd: begin
				result = sum;
			end
			aluSub: begin
				result = diff;
			end
			aluAnd: begin
				result = a & b;
			end
			aluOr: begin
				result = a | b;
			end
			aluXor: begin
				result = a ^ b;
			end
			default: begin
				result = '0;		// Unknown function gives zero
			end
		endcase
	end

	always_comb begin
		case (cond)
			cmpEq: begin
				cmpT = isEq;
			end
			cmpGt: begin
				cmpT = isGt;
			end
			default: begin
				cmpT = 1'b0;		// Unknown condition clears T
			end
		endcase
	end

endmodule

`default_nettype wire

/* exLaneMulw.sv */
// Two-step signed 32x32 multiplier
`timescale 1ns/1ps
`default_nettype none

module exLaneMulw (
	input wire clock,
	input wire reset,
	input wire advance,
	input wire signed [31:0] a,
	input wire signed [31:0] b,
	output logic [laneDefs::laneDataWidth-1:0] product
);
	import laneDefs::*;

	logic signed [16:0] aLo;		// Low halves, zero extended
	logic signed [16:0] bLo;
	logic signed [15:0] aHi;		// High halves carry the sign
	logic signed [15:0] bHi;

	logic [31:0] pLL;		// Unsigned lo*lo
	logic signed [32:0] pLH;		// aLo * bHi
	logic signed [32:0] pHL;		// aHi * bLo
	logic signed [31:0] pHH;		// Signed hi*hi

	assign aLo = {1'b0, a[15:0]};
	assign bLo = {1'b0, b[15:0]};
	assign aHi = a[31:16];
	assign bHi = b[31:16];

	// Step one, EX1 cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			pLL <= '0;
			pLH <= '0;
			pHL <= '0;
			pHH <= '0;
		end else if (advance) begin
			pLL <= a[15:0] * b[15:0];
			pLH <= aLo * bHi;
			pHL <= aHi * bLo;
			pHH <= aHi * bHi;
		end
	end

	// Step two in EX2, cross terms shifted by 16, hi*hi by 32
	assign product = {pHH, 32'd0}
		+ {{15{pLH[32]}}, pLH, 16'd0}
		+ {{15{pHL[32]}}, pHL, 16'd0}
		+ {{(laneDataWidth-32){1'b0}}, pLL};

endmodule

`default_nettype wire

/* exLaneStage1.sv */
// Lane EX1 stage
// Predication, ALU result and multiply start
`timescale 1ns/1ps
`default_nettype none

module exLaneStage1 (
	input wire clock,
	input wire reset,
	input wire advance,
	input wire laneDefs::laneIssue issue,
	input wire issueValid,
	input wire nextT,		// T after the op in EX2
	output laneDefs::laneEx1Op ex1Op,
	output logic ex1Valid,
	output logic [31:0] mulA,
	output logic [31:0] mulB
);
	import laneDefs::*;

	laneIssue regA;		// Pipeline register A
	logic validA;
	logic opEnable;		// Predication passed
	laneUCmd effCmd;
	logic [laneDataWidth-1:0] aluResult;
	logic aluCmpT;
	logic [laneDataWidth-1:0] immExt;

	always_ff @(posedge clock) begin
		if (reset) begin
			validA <= 1'b0;
		end else if (advance) begin
			validA <= issueValid;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			regA <= issue;
		end
	end

	exLaneAlu alu (
		.func(regA.ixt.aluFunc),
		.cond(regA.ixt.cmpCond),
		.a(regA.valRs),
		.b(regA.valRt),
		.result(aluResult),
		.cmpT(aluCmpT)
	);

	assign immExt = {{(laneDataWidth-laneImmWidth){regA.imm[laneImmWidth-1]}}, regA.imm};

	// Compare in EX2 is visible here through nextT
	always_comb begin
		case (regA.op.pred)
			predAlways: opEnable = 1'b1;
			predNever: opEnable = 1'b0;
			predIfT: opEnable = nextT;
			predIfNt: opEnable = !nextT;
			default: opEnable = 1'b0;
		endcase
		effCmd = opEnable ? regA.op.uCmd : uCmdNop;
	end

	always_comb begin
		ex1Op.op.pred = opEnable ? regA.op.pred : predNever;
		ex1Op.op.uCmd = effCmd;
		ex1Op.ixt = regA.ixt;
		ex1Op.regIdRn = regA.regIdRn;
		ex1Op.write = 1'b0;		// No write unless the command has one
		ex1Op.cmpT = 1'b0;
		ex1Op.value = '0;
		case (effCmd)
			uCmdMovIr: begin
				ex1Op.write = 1'b1;
				ex1Op.value = immExt;
			end
			uCmdAlu3: begin
				ex1Op.write = 1'b1;
				ex1Op.value = aluResult;
			end
			uCmdAluCmp: begin
				ex1Op.cmpT = aluCmpT;		// Committed in EX2
			end
			uCmdMulw3: begin
				ex1Op.write = 1'b1;		// Value pending, EX2 fills product
			end
			default: begin
			end
		endcase
	end

	assign ex1Valid = validA;
	assign mulA = regA.valRs[31:0];		// Low words into multiplier
	assign mulB = regA.valRt[31:0];

endmodule

`default_nettype wire

/* exLaneStage2.sv */
// Lane EX2 stage
// Destination select, T commit and writeback register
`timescale 1ns/1ps
`default_nettype none

module exLaneStage2 (
	input wire clock,
	input wire reset,
	input wire advance,
	input wire laneDefs::laneEx1Op ex1Op,
	input wire ex1Valid,
	input wire [laneDefs::laneDataWidth-1:0] mulProduct,
	input wire flush,
	output logic nextT,
	output logic tBit,
	output laneDefs::laneWb wb,
	output logic wbValid
);
	import laneDefs::*;

	laneEx1Op regB;		// Pipeline register B
	logic validB;
	logic tReg;		// Committed T
	laneWb wbNext;

	always_ff @(posedge clock) begin
		if (reset) begin
			validB <= 1'b0;
		end else if (advance) begin
			validB <= ex1Valid;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			regB <= ex1Op;
		end
	end

	always_comb begin
		wbNext.write = regB.write;		// Forward EX1 by default
		wbNext.regId = regB.regIdRn;
		wbNext.value = regB.value;
		if (regB.op.uCmd == uCmdMulw3) begin
			wbNext.value = mulProduct;		// Multiply finishes here
		end
		if (flush) begin
			wbNext.write = 1'b0;		// Flushed op still emits a record
		end
	end

	// T seen by EX1 predication, one op ahead
	always_comb begin
		nextT = tReg;
		if (validB && !flush && regB.op.uCmd == uCmdAluCmp) begin
			nextT = regB.cmpT;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tReg <= 1'b0;
			wbValid <= 1'b0;
		end else if (advance) begin
			tReg <= nextT;
			wbValid <= validB;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			wb <= wbNext;		// Output record
		end
	end

	assign tBit = tReg;

endmodule

`default_nettype wire

/* exLaneTb.sv */
// Lane testbench
// Directed tests with reference model
`timescale 1ns/1ps
`default_nettype none

module exLaneTb;
	import laneDefs::*;

	logic clock;
	logic reset;
	laneIssue issue;
	logic issueValid;
	logic issueReady;
	laneWb wb;
	logic wbValid;
	logic wbReady;
	logic flush;
	logic tBit;

	integer seed;
	integer stallSeed;		// Own stream for the consumer stalls
	int cycle;		// Global cycle count for timeout
	string testName;
	logic modelT;		// Reference T in issue order
	logic issueFlush;		// Flush the op now being issued
	logic flushA;		// Flush flag follows the op through A
	logic stallMode;
	logic checkLatency;
	int stallCount;
	laneWb expWb[$];
	logic expT[$];
	int expCycle[$];

	exLaneTop dut (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.issueValid(issueValid),
		.issueReady(issueReady),
		.wb(wb),
		.wbValid(wbValid),
		.wbReady(wbReady),
		.flush(flush),
		.tBit(tBit)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Run limit well above the test length
	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= 2000) begin
			$display("Timeout, lane did not finish within 2000 cycles");
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	// Flush reaches the DUT while its op sits in B
	always @(posedge clock) begin
		if (reset) begin
			flushA <= 1'b0;
			flush <= 1'b0;
		end else if (issueReady) begin
			flushA <= issueValid && issueFlush;
			flush <= flushA;
		end
	end

	// Random consumer stalls
	always @(posedge clock) begin
		if (!stallMode) begin
			wbReady <= 1'b1;
			stallCount <= 0;
		end else if (stallCount == 0) begin
			wbReady <= ~wbReady;
			stallCount <= ($random(stallSeed) & 7) + 1;
		end else begin
			stallCount <= stallCount - 1;
		end
	end

	task automatic compareWb(input laneWb expected, input laneWb actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %h actual %h", testName, expected, actual);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic compareT(input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected T %b actual T %b", testName, expected, actual);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	// Record monitor on pre-edge values
	always @(posedge clock) begin
		if (!reset && wbValid && !wbReady && issueReady) begin
			$display("Issue side still ready while a record waits in %s", testName);
			$display("TESTS FAILED");
			$fatal(1);
		end
		if (!reset && wbValid && wbReady) begin
			if (expWb.size() == 0) begin
				$display("Unexpected extra record in %s", testName);
				$display("TESTS FAILED");
				$fatal(1);
			end
			compareWb(expWb.pop_front(), wb);
			compareT(expT.pop_front(), tBit);
			if (checkLatency && cycle - expCycle[0] != 3) begin
				$display("Record latency wrong in %s", testName);
				$display("TESTS FAILED");
				$fatal(1);
			end
			void'(expCycle.pop_front());
		end
	end

	// Reference model of one op and of T
	function automatic laneWb modelOp(input laneIssue op, input logic fl);
		laneWb r;
		logic enable;
		logic newT;
		laneUCmd cmd;
		logic [63:0] rs;
		logic [63:0] rt;
		rs = op.valRs;
		rt = op.valRt;
		case (op.op.pred)
			predAlways: enable = 1'b1;
			predIfT: enable = modelT;
			predIfNt: enable = !modelT;
			default: enable = 1'b0;
		endcase
		cmd = enable ? op.op.uCmd : uCmdNop;
		r.write = 1'b0;
		r.regId = op.regIdRn;
		r.value = '0;
		case (cmd)
			uCmdMovIr: begin
				r.write = 1'b1;
				r.value = {{31{op.imm[32]}}, op.imm};
			end
			uCmdAlu3: begin
				r.write = 1'b1;
				case (op.ixt.aluFunc)
					aluAdd: r.value = rs + rt;
					aluSub: r.value = rs - rt;
					aluAnd: r.value = rs & rt;
					aluOr: r.value = rs | rt;
					default: r.value = rs ^ rt;
				endcase
			end
			uCmdAluCmp: begin
				if (op.ixt.cmpCond == cmpEq) newT = (rs == rt);
				else newT = ($signed(rs) > $signed(rt));
				if (!fl) modelT = newT;		// Flushed compare keeps T
			end
			uCmdMulw3: begin
				r.write = 1'b1;
				r.value = longint'($signed(rs[31:0])) * longint'($signed(rt[31:0]));
			end
			default: begin
			end
		endcase
		if (fl) r.write = 1'b0;
		return r;
	endfunction

	function automatic laneIssue makeOp(input lanePred pred, input laneUCmd cmd,
		input logic [7:0] ixt);
		laneIssue op;
		op.op.pred = pred;
		op.op.uCmd = cmd;
		op.ixt = ixt;
		op.regIdRs = laneRegIdWidth'($random(seed));
		op.regIdRt = laneRegIdWidth'($random(seed));
		op.regIdRn = laneRegIdWidth'($random(seed));
		op.valRs = {$random(seed), $random(seed)};
		op.valRt = {$random(seed), $random(seed)};
		op.imm = laneImmWidth'({$random(seed), $random(seed)});
		if (($random(seed) & 3) == 0) op.valRt = op.valRs;		// Hits EQ sometimes
		return op;
	endfunction

	// Hold the op until accepted and queue its expectation
	task automatic sendOp(input laneIssue op, input logic fl);
		issue <= op;
		issueValid <= 1'b1;
		issueFlush <= fl;
		do @(posedge clock); while (!issueReady);
		expWb.push_back(modelOp(op, fl));
		expT.push_back(modelT);
		expCycle.push_back(cycle);
	endtask

	task automatic drain();
		issueValid <= 1'b0;
		issueFlush <= 1'b0;
		while (expWb.size() != 0) @(posedge clock);
		@(posedge clock);
	endtask

	task automatic testAluBasic();
		testName = "aluBasic";
		checkLatency = 1'b1;
		for (int i = 0; i < 6; i++) begin
			sendOp(makeOp(predAlways, uCmdMovIr, 8'h00), 1'b0);
			sendOp(makeOp(predAlways, uCmdAlu3, aluAdd), 1'b0);
			sendOp(makeOp(predAlways, uCmdAlu3, aluSub), 1'b0);
			sendOp(makeOp(predAlways, uCmdAlu3, aluAnd), 1'b0);
			sendOp(makeOp(predAlways, uCmdAlu3, aluOr), 1'b0);
			sendOp(makeOp(predAlways, uCmdAlu3, aluXor), 1'b0);
		end
		drain();
		checkLatency = 1'b0;
	endtask

	task automatic testMulw();
		testName = "mulw";
		for (int i = 0; i < 16; i++) sendOp(makeOp(predAlways, uCmdMulw3, 8'h00), 1'b0);
		drain();
	endtask

	task automatic testCompare();
		testName = "compare";
		for (int i = 0; i < 12; i++) begin
			sendOp(makeOp(predAlways, uCmdAluCmp, (i % 2) ? cmpGt : cmpEq), 1'b0);
			sendOp(makeOp(predIfT, uCmdAlu3, aluAdd), 1'b0);		// Directly behind
			sendOp(makeOp(predIfNt, uCmdAlu3, aluXor), 1'b0);
			sendOp(makeOp(predIfT, uCmdMulw3, 8'h00), 1'b0);
		end
		drain();
	endtask

	task automatic testNeverFlush();
		testName = "neverFlush";
		for (int i = 0; i < 10; i++) begin
			sendOp(makeOp(predNever, uCmdAlu3, aluOr), 1'b0);
			sendOp(makeOp(predAlways, uCmdAlu3, aluSub), 1'b1);
			sendOp(makeOp(predAlways, uCmdAluCmp, cmpGt), 1'b0);
			sendOp(makeOp(predAlways, uCmdAluCmp, cmpEq), 1'b1);		// T must stay
			sendOp(makeOp(predIfT, uCmdMovIr, 8'h00), 1'b0);
			sendOp(makeOp(predAlways, uCmdMulw3, 8'h00), 1'b1);
		end
		drain();
	endtask

	task automatic testBackPressure();
		lanePred pred;
		laneUCmd cmd;
		testName = "backPressure";
		stallMode <= 1'b1;
		for (int i = 0; i < 60; i++) begin
			pred = lanePred'($random(seed) & 3);
			case ($random(seed) & 3)
				0: cmd = uCmdMovIr;
				1: cmd = uCmdAlu3;
				2: cmd = uCmdAluCmp;
				default: cmd = uCmdMulw3;
			endcase
			sendOp(makeOp(pred, cmd, (cmd == uCmdAluCmp) ? cmpGt : aluAdd),
				($random(seed) & 7) == 0);
		end
		issueValid <= 1'b0;
		repeat (20) @(posedge clock);		// Stalls continue with ops queued
		stallMode <= 1'b0;
		drain();
	endtask

	initial begin
		seed = 32'h52e5_2fc4;
		stallSeed = 32'h52e5_2fc4;
		cycle <= 0;
		modelT = 1'b0;
		reset <= 1'b1;
		issue <= '0;
		issueValid <= 1'b0;
		issueFlush <= 1'b0;
		flush <= 1'b0;
		wbReady <= 1'b1;
		stallMode <= 1'b0;
		checkLatency = 1'b0;
		testName = "reset";
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		testAluBasic();
		testMulw();
		testCompare();
		testNeverFlush();
		testBackPressure();
		if (expWb.size() == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("Records missing at end of run");
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* exLaneTop.sv */
// Second execution lane, top level
`timescale 1ns/1ps
`default_nettype none

module exLaneTop (
	input wire clock,
	input wire reset,
	input wire laneDefs::laneIssue issue,
	input wire issueValid,
	output logic issueReady,
	output laneDefs::laneWb wb,
	output logic wbValid,
	input wire wbReady,
	input wire flush,
	output logic tBit
);
	import laneDefs::*;

	logic advance;		// Whole lane moves together
	laneEx1Op ex1Op;
	logic ex1Valid;
	logic [31:0] mulA;
	logic [31:0] mulB;
	logic [laneDataWidth-1:0] mulProduct;
	logic nextT;

	// Stall only on a record the consumer has not taken
	assign advance = !(wbValid && !wbReady);
	assign issueReady = advance;

	exLaneStage1 stage1 (
		.clock(clock),
		.reset(reset),
		.advance(advance),
		.issue(issue),
		.issueValid(issueValid),
		.nextT(nextT),
		.ex1Op(ex1Op),
		.ex1Valid(ex1Valid),
		.mulA(mulA),
		.mulB(mulB)
	);

	exLaneMulw mulw (
		.clock(clock),
		.reset(reset),
		.advance(advance),
		.a(mulA),
		.b(mulB),
		.product(mulProduct)
	);

	exLaneStage2 stage2 (
		.clock(clock),
		.reset(reset),
		.advance(advance),
		.ex1Op(ex1Op),
		.ex1Valid(ex1Valid),
		.mulProduct(mulProduct),
		.flush(flush),
		.nextT(nextT),
		.tBit(tBit),
		.wb(wb),
		.wbValid(wbValid)
	);

endmodule

`default_nettype wire

/* laneDefs.sv */
// Execution lane shared types
// Widths, encodings and lane records
`default_nettype none

package laneDefs;

	localparam int laneRegIdWidth = 6;		// GPR id bits
	localparam int laneDataWidth = 64;		// Datapath width
	localparam int laneImmWidth = 33;		// Decoded immediate, sign bit on top

	// Micro-op commands, low six bits of the op byte
	typedef enum logic [5:0] {
		uCmdNop		= 6'h00,
		uCmdMovIr	= 6'h01,		// Immediate to Rn
		uCmdAlu3	= 6'h04,		// Rn = Rs op Rt
		uCmdAluCmp	= 6'h05,		// T = Rs cond Rt
		uCmdMulw3	= 6'h08		// Rn = Rs.l * Rt.l, finishes in EX2
	} laneUCmd;

	// Predication, top two bits of the op byte
	typedef enum logic [1:0] {
		predAlways	= 2'b00,
		predNever	= 2'b01,
		predIfT		= 2'b10,
		predIfNt	= 2'b11
	} lanePred;

	typedef struct packed {
		lanePred pred;
		laneUCmd uCmd;
	} laneOp;

	typedef enum logic [7:0] {
		aluAdd	= 8'h00,
		aluSub	= 8'h01,
		aluAnd	= 8'h05,
		aluOr	= 8'h06,
		aluXor	= 8'h07
	} laneAluFunc;

	typedef enum logic [7:0] {
		cmpEq	= 8'h00,
		cmpGt	= 8'h01		// Signed
	} laneCmpCond;

	// Same extension byte, read per command
	typedef union packed {
		laneAluFunc aluFunc;		// ALU3
		laneCmpCond cmpCond;		// ALUCMP
	} laneIxt;

	typedef struct packed {
		laneOp op;
		laneIxt ixt;
		logic [laneRegIdWidth-1:0] regIdRs;
		logic [laneRegIdWidth-1:0] regIdRt;
		logic [laneRegIdWidth-1:0] regIdRn;		// Destination
		logic [laneDataWidth-1:0] valRs;
		logic [laneDataWidth-1:0] valRt;
		logic [laneImmWidth-1:0] imm;
	} laneIssue;

	// EX1 output toward EX2
	typedef struct packed {
		laneOp op;		// Effective op, NOP if predicated off
		laneIxt ixt;
		logic write;
		logic cmpT;		// Compare outcome for ALUCMP
		logic [laneRegIdWidth-1:0] regIdRn;
		logic [laneDataWidth-1:0] value;
	} laneEx1Op;

	typedef struct packed {
		logic write;
		logic [laneRegIdWidth-1:0] regId;
		logic [laneDataWidth-1:0] value;
	} laneWb;

endpackage

`default_nettype wire
